// ==== all.f ====
+incdir+common
common/fixed_pkg.sv
common/vertex_pkg.sv
rtl/fx_mul.sv
rtl/fx_recip.sv
projector/tri_proj.sv
rtl/proj_fifo.sv
rtl/wb_vertex_port.sv
rtl/proj_top.sv
testbench/tb_proj.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the projection unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    --top-module tb_proj -f all.f -o sim_proj
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_proj 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// ==== testbench/tb_proj.sv ====
`timescale 1ns/10ps

`include "proj_consts.svh"

module tb_proj;

    // the last back-pressure vertex is one more than both FIFOs and the engine can hold
    localparam int BP_COUNT      = 2 * `PROJ_FIFO_DEPTH + 2;
    localparam int NUM_VERTICES  = 4 + 40 + 3 + BP_COUNT;
    localparam int TIMEOUT_LIMIT = NUM_VERTICES * 120 + 2000;

    logic        clk_in;
    logic        rst_in;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    integer seed;
    int     cycles = 0;

    vertex_pkg::screen_pt_t expect_q[$];   // model results in write order

    proj_top u_proj_top (
        .clk_in(clk_in), .rst_in(rst_in),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    endtask

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_LIMIT)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT));
    end

    // a patience of 0 waits for ack with no limit
    task automatic bus_cycle(input logic wr, input logic [2:0] a, input logic [31:0] d,
                             input int patience, output logic [31:0] q, output logic acked);
        int n;
        n     = 0;
        acked = 1'b0;
        @(posedge clk_in);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        while (!acked && (patience == 0 || n < patience)) begin
            @(negedge clk_in);   // ack and dat_r are settled here
            acked = ack;
            n++;
        end
        q = dat_r;
        @(posedge clk_in);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] q;
        logic        acked;
        bus_cycle(1'b1, a, d, 0, q, acked);
    endtask

    task automatic wb_read(input logic [2:0] a, output logic [31:0] q);
        logic acked;
        bus_cycle(1'b0, a, 32'd0, 0, q, acked);
    endtask

    // Q16.16 product, rescaled and truncated
    function automatic fixed_pkg::fx_t ref_mul(input fixed_pkg::fx_t a, input fixed_pkg::fx_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return fixed_pkg::fx_t'(p >>> 16);
    endfunction

    function automatic fixed_pkg::fx_t ref_recip(input fixed_pkg::fx_t v);
        longint mag;
        longint q;
        mag = (v < 0) ? -longint'(v) : longint'(v);
        q   = (mag == 0) ? 64'sh7FFF_FFFF : (64'sh1_0000_0000 / mag);
        if (q > 64'sh7FFF_FFFF)
            q = 64'sh7FFF_FFFF;   // also covers |v| of 1 and 2
        return (v < 0) ? fixed_pkg::fx_t'(-q) : fixed_pkg::fx_t'(q);
    endfunction

    task automatic add_expected(input fixed_pkg::fx_t x, input fixed_pkg::fx_t y,
                                input fixed_pkg::fx_t z, input logic od);
        fixed_pkg::fx_t         s;
        vertex_pkg::screen_pt_t e;
        s          = ref_recip(ref_mul(z, `PROJ_RECIP_D));
        e.x        = ref_mul(x, s);
        e.y        = ref_mul(y, s);
        e.obj_done = od;
        expect_q.push_back(e);
    endtask

    task automatic stage_vertex(input fixed_pkg::fx_t x, input fixed_pkg::fx_t y,
                                input fixed_pkg::fx_t z);
        wb_write(`WB_ADDR_X, x);
        wb_write(`WB_ADDR_Y, y);
        wb_write(`WB_ADDR_Z, z);
    endtask

    task automatic send_vertex(input fixed_pkg::fx_t x, input fixed_pkg::fx_t y,
                               input fixed_pkg::fx_t z, input logic od);
        stage_vertex(x, y, z);
        wb_write(`WB_ADDR_CTRL, {31'd0, od});
        add_expected(x, y, z, od);
    endtask

    // z in [0.5, 64), x and y in (-256, 256)
    task automatic rand_vertex(output fixed_pkg::fx_t x, output fixed_pkg::fx_t y,
                               output fixed_pkg::fx_t z, output logic od);
        integer r;
        x  = $random(seed) % 32'sd16777216;
        y  = $random(seed) % 32'sd16777216;
        z  = 32'h8000 + ($unsigned($random(seed)) % 32'd4161536);
        r  = $random(seed);
        od = r[0];
    endtask

    task automatic read_result(input string name);
        logic [31:0]            st;
        logic [31:0]            rx;
        logic [31:0]            ry;
        logic [31:0]            rp;
        vertex_pkg::screen_pt_t e;
        st = 32'd0;
        while (!st[0]) wb_read(`WB_ADDR_CTRL, st);
        wb_read(`WB_ADDR_SX, rx);
        wb_read(`WB_ADDR_SY, ry);
        wb_read(`WB_ADDR_POP, rp);
        e = expect_q.pop_front();
        check({name, " x"}, e.x, rx);
        check({name, " y"}, e.y, ry);
        check({name, " obj_done"}, {31'd0, e.obj_done}, rp);
    endtask

    task automatic drain(input string name);
        while (expect_q.size() > 0) read_result(name);
    endtask

    initial begin
        logic [31:0]    st;
        logic [31:0]    r;
        logic           acked;
        fixed_pkg::fx_t x;
        fixed_pkg::fx_t y;
        fixed_pkg::fx_t z;
        logic           od;

        seed   = 32'h7563_1cfb;
        rst_in = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 3'd0;
        dat_w  = 32'd0;
        repeat (16) @(posedge clk_in);
        rst_in <= 1'b0;

        // nothing queued yet
        wb_read(`WB_ADDR_CTRL, st);
        check("empty status", 32'd0, st);
        wb_read(`WB_ADDR_POP, r);
        check("empty pop", 32'd0, r);
        wb_read(`WB_ADDR_CTRL, st);
        check("status after empty pop", 32'd0, st);

        // z = 5.0 gives s close to 1.0
        send_vertex(32'sh0002_0000, 32'sh0003_0000, 32'sh0005_0000, 1'b0);
        send_vertex(-32'sh0002_0000, 32'sh0003_0000, 32'sh0005_0000, 1'b1);
        send_vertex(32'sh0002_0000, -32'sh0003_0000, 32'sh0005_0000, 1'b0);
        send_vertex(-32'sh0002_0000, -32'sh0003_0000, 32'sh0005_0000, 1'b1);
        drain("directed");

        for (int i = 0; i < 40; i++) begin
            rand_vertex(x, y, z, od);
            send_vertex(x, y, z, od);
            if (i % 4 == 3) drain("random");
        end

        send_vertex(32'sh0003_0000, -32'sh0001_8000, 32'sh0000_0000, 1'b1);   // z = 0
        send_vertex(32'sh0001_0000, -32'sh0002_0000, 32'sh0000_0006, 1'b0);   // z*1/d = 1 lsb
        send_vertex(32'sh0004_0000, 32'sh0001_4000, -32'sh0005_0000, 1'b1);
        drain("saturation");

        // fill the input FIFO, the engine and the result FIFO without reading
        for (int i = 0; i < BP_COUNT - 1; i++) begin
            rand_vertex(x, y, z, od);
            send_vertex(x, y, z, od);
        end
        st = 32'd0;
        while (!st[1]) wb_read(`WB_ADDR_CTRL, st);
        check("backpressure status", 32'd3, st);
        rand_vertex(x, y, z, od);
        stage_vertex(x, y, z);
        bus_cycle(1'b1, `WB_ADDR_CTRL, {31'd0, od}, 40, r, acked);
        check("backpressure ack withheld", 32'd0, {31'd0, acked});
        read_result("backpressure");
        bus_cycle(1'b1, `WB_ADDR_CTRL, {31'd0, od}, 40, r, acked);
        check("backpressure ack granted", 32'd1, {31'd0, acked});
        add_expected(x, y, z, od);
        drain("backpressure");

        wb_read(`WB_ADDR_POP, r);
        check("final empty pop", 32'd0, r);
        wb_read(`WB_ADDR_CTRL, st);
        check("final status", 32'd0, st);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== rtl/proj_top.sv ====
`timescale 1ns/10ps

`include "proj_consts.svh"

module proj_top (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    vertex_pkg::vertex_t    wr_vtx, rd_vtx;
    vertex_pkg::screen_pt_t eng_pt, head_pt;
    logic vtx_push, vtx_full, vtx_empty, vtx_take;
    logic pt_valid, pt_full, pt_empty, pt_pop;

    wb_vertex_port u_wb (
        .clk_in(clk_in), .rst_in(rst_in),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .vtx_push(vtx_push), .vtx(wr_vtx), .vtx_full(vtx_full),
        .pt(head_pt), .pt_empty(pt_empty), .pt_pop(pt_pop)
    );

    proj_fifo #(.payload_t(vertex_pkg::vertex_t), .DEPTH(`PROJ_FIFO_DEPTH)) u_vtx_fifo (
        .clk_in(clk_in), .rst_in(rst_in),
        .push(vtx_push), .wdata(wr_vtx), .full(vtx_full),
        .pop(vtx_take), .rdata(rd_vtx), .empty(vtx_empty)
    );

    tri_proj u_proj (
        .clk_in(clk_in), .rst_in(rst_in),
        .vtx(rd_vtx), .vtx_valid(!vtx_empty), .vtx_take(vtx_take),
        .pt(eng_pt), .pt_valid(pt_valid), .pt_ready(!pt_full)
    );

    proj_fifo #(.payload_t(vertex_pkg::screen_pt_t), .DEPTH(`PROJ_FIFO_DEPTH)) u_pt_fifo (
        .clk_in(clk_in), .rst_in(rst_in),
        .push(pt_valid), .wdata(eng_pt), .full(pt_full),
        .pop(pt_pop), .rdata(head_pt), .empty(pt_empty)
    );

endmodule

// ==== rtl/wb_vertex_port.sv ====
`timescale 1ns/10ps

`include "proj_consts.svh"

module wb_vertex_port (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [2:0]             adr,
    input  logic [31:0]            dat_w,
    output logic [31:0]            dat_r,
    output logic                   ack,
    output logic                   vtx_push,
    output vertex_pkg::vertex_t    vtx,
    input  logic                   vtx_full,
    input  vertex_pkg::screen_pt_t pt,
    input  logic                   pt_empty,
    output logic                   pt_pop
);

    fixed_pkg::fx_t stg_x;
    fixed_pkg::fx_t stg_y;
    fixed_pkg::fx_t stg_z;

    logic        ctrl_wr;
    logic        fire;
    logic [31:0] rd_word;

    assign ctrl_wr = we && (adr == `WB_ADDR_CTRL);
    // hold off the ack on a push while the input FIFO is full
    assign fire    = cyc && stb && !ack && !(ctrl_wr && vtx_full);

    assign vtx_push = fire && ctrl_wr;
    assign vtx      = '{x: stg_x, y: stg_y, z: stg_z, obj_done: dat_w[0]};
    assign pt_pop   = fire && !we && (adr == `WB_ADDR_POP) && !pt_empty;

    always_comb begin
        case (adr)
            `WB_ADDR_CTRL: rd_word = {30'd0, vtx_full, !pt_empty};
            `WB_ADDR_SX:   rd_word = pt.x;
            `WB_ADDR_SY:   rd_word = pt.y;
            `WB_ADDR_POP:  rd_word = pt_empty ? 32'd0 : {31'd0, pt.obj_done};
            default:       rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack <= 1'b0;
        end else begin
            ack <= fire;   // single-cycle ack
        end
    end

    always_ff @(posedge clk_in) begin
        if (fire && we) begin
            case (adr)
                `WB_ADDR_X: stg_x <= dat_w;
                `WB_ADDR_Y: stg_y <= dat_w;
                `WB_ADDR_Z: stg_z <= dat_w;
                default: ;
            endcase
        end
        if (fire && !we) dat_r <= rd_word;
    end

endmodule

// ==== rtl/proj_fifo.sv ====
`timescale 1ns/10ps

module proj_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     push,
    input  payload_t wdata,
    output logic     full,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];   // head is always on rdata

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

endmodule

// ==== projector/tri_proj.sv ====
`timescale 1ns/10ps

`include "proj_consts.svh"

module tri_proj (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  vertex_pkg::vertex_t    vtx,
    input  logic                   vtx_valid,
    output logic                   vtx_take,
    output vertex_pkg::screen_pt_t pt,
    output logic                   pt_valid,
    input  logic                   pt_ready
);

    typedef enum logic [2:0] {
        IDLE,
        SCALE,    // z * 1/d
        RECIP,    // s = 1 / (z/d)
        MUL_X,
        MUL_Y,
        OUT
    } state_t;

    state_t state;

    vertex_pkg::vertex_t vtx_q;
    fixed_pkg::fx_t      pt_x;
    fixed_pkg::fx_t      pt_y;

    logic           mul_valid;
    fixed_pkg::fx_t mul_a;
    fixed_pkg::fx_t mul_b;
    fixed_pkg::fx_t mul_result;
    logic           mul_rv;

    logic           rcp_start;
    fixed_pkg::fx_t rcp_result;
    logic           rcp_done;
    logic           rcp_busy;

    fx_mul u_mul (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .valid       (mul_valid),
        .a           (mul_a),
        .b           (mul_b),
        .result      (mul_result),
        .result_valid(mul_rv)
    );

    fx_recip u_recip (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .start  (rcp_start),
        .operand(mul_result),
        .result (rcp_result),
        .done   (rcp_done),
        .busy   (rcp_busy)
    );

    assign vtx_take  = (state == IDLE) && vtx_valid;
    assign rcp_start = (state == SCALE) && mul_rv && !rcp_busy;
    assign pt_valid  = (state == OUT);
    assign pt        = '{x: pt_x, y: pt_y, obj_done: vtx_q.obj_done};

    // one multiplier shared by all three products
    always_comb begin
        mul_valid = 1'b0;
        mul_a     = vtx.z;
        mul_b     = `PROJ_RECIP_D;
        case (state)
            IDLE:  mul_valid = vtx_valid;
            RECIP: begin
                mul_valid = rcp_done;
                mul_a     = vtx_q.x;
                mul_b     = rcp_result;
            end
            MUL_X: begin
                mul_valid = mul_rv;   // issue y*s as x*s lands
                mul_a     = vtx_q.y;
                mul_b     = rcp_result;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (vtx_valid) state <= SCALE;
                SCALE:   if (rcp_start) state <= RECIP;
                RECIP:   if (rcp_done) state <= MUL_X;
                MUL_X:   if (mul_rv) state <= MUL_Y;
                MUL_Y:   if (mul_rv) state <= OUT;
                OUT:     if (pt_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (vtx_take) vtx_q <= vtx;
        if (state == MUL_X && mul_rv) pt_x <= mul_result;
        if (state == MUL_Y && mul_rv) pt_y <= mul_result;
    end

endmodule

// ==== rtl/fx_recip.sv ====
`timescale 1ns/10ps

module fx_recip (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           start,
    input  fixed_pkg::fx_t operand,
    output fixed_pkg::fx_t result,
    output logic           done,
    output logic           busy
);

    logic [5:0]  cnt;       // quotient steps left
    logic        neg;
    logic [31:0] divisor;   // |operand|
    logic [31:0] rem;
    logic [32:0] quo;
    logic [32:0] rem_sh;
    logic [32:0] rem_sub;
    logic        ge;
    logic [31:0] q_sat;

    // dividend is 2^32, so only the first step shifts in a one
    assign rem_sh  = {rem, cnt == 6'd33};
    assign rem_sub = rem_sh - {1'b0, divisor};
    assign ge      = rem_sh >= {1'b0, divisor};

    assign q_sat = (quo[32] || quo[31]) ? 32'h7FFF_FFFF : quo[31:0];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    cnt  <= 6'd33;
                end
            end else if (cnt != 6'd0) begin
                cnt <= cnt - 6'd1;
            end else begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!busy) begin
            neg     <= operand[31];
            divisor <= operand[31] ? 32'(-operand) : 32'(operand);
            rem     <= '0;
            quo     <= '0;
        end else if (cnt != 6'd0) begin
            rem <= ge ? rem_sub[31:0] : rem_sh[31:0];
            quo <= {quo[31:0], ge};
        end else begin
            result <= neg ? -fixed_pkg::fx_t'(q_sat) : fixed_pkg::fx_t'(q_sat);
        end
    end

endmodule

// ==== rtl/fx_mul.sv ====
`timescale 1ns/10ps

module fx_mul (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           valid,
    input  fixed_pkg::fx_t a,
    input  fixed_pkg::fx_t b,
    output fixed_pkg::fx_t result,
    output logic           result_valid
);

    fixed_pkg::fx_wide_t prod;
    logic                prod_valid;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_valid   <= valid;
            result_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        prod   <= fixed_pkg::fx_wide_t'(a) * fixed_pkg::fx_wide_t'(b);   // stage 1
        result <= fixed_pkg::fx_t'(prod >>> 16);   // stage 2, back to Q16.16
    end

endmodule

// ==== common/vertex_pkg.sv ====
package vertex_pkg;

    // camera-space vertex as written by the host
    typedef struct packed {
        fixed_pkg::fx_t x;
        fixed_pkg::fx_t y;
        fixed_pkg::fx_t z;
        logic           obj_done;   // last vertex of an object
    } vertex_t;

    // projected point handed back to the host
    typedef struct packed {
        fixed_pkg::fx_t x;
        fixed_pkg::fx_t y;
        logic           obj_done;
    } screen_pt_t;

endpackage

// ==== common/fixed_pkg.sv ====
package fixed_pkg;

    // signed Q16.16, 16 integer bits and 16 fraction bits
    typedef logic signed [31:0] fx_t;

    // full product of two fx_t values, Q32.32 before rescaling
    typedef logic signed [63:0] fx_wide_t;

endpackage

// ==== common/proj_consts.svh ====
`ifndef PROJ_CONSTS_SVH
`define PROJ_CONSTS_SVH

// 1/d in Q16.16 for d = 5
`define PROJ_RECIP_D    32'sh0000_3333

`define PROJ_FIFO_DEPTH 4

// wishbone word addresses
`define WB_ADDR_X       3'd0
`define WB_ADDR_Y       3'd1
`define WB_ADDR_Z       3'd2
`define WB_ADDR_CTRL    3'd3   // write: push vertex, read: status
`define WB_ADDR_SX      3'd4
`define WB_ADDR_SY      3'd5
`define WB_ADDR_POP     3'd6   // read pops the head result

`endif
